// ==== design/id_pkg.sv ====
package id_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int LINK_REG   = 31;
    localparam logic [DATA_W-1:0] ZERO_WORD = '0;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // SPECIAL function field, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    // REGIMM rt field
    typedef enum logic [4:0] {
        RI_BLTZ   = 5'h00,
        RI_BGEZ   = 5'h01,
        RI_BLTZAL = 5'h10,
        RI_BGEZAL = 5'h11
    } regimm_e;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU, ALU_LINK
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_JUMP
    } alu_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_J, BR_JR, BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_GEZ, BR_LTZ
    } branch_kind_e;

    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     data;
    } fwd_t;

    typedef struct packed {
        alu_op_e               alu_op;
        alu_sel_e              alu_sel;
        logic                  rd_en1;
        logic                  rd_en2;
        logic [REG_ADDR_W-1:0] rd_addr1;
        logic [REG_ADDR_W-1:0] rd_addr2;
        logic                  wr_en;
        logic [REG_ADDR_W-1:0] wr_addr;
        logic [DATA_W-1:0]     imm;
        branch_kind_e          branch_kind;
        logic                  link;
        logic [DATA_W-1:0]     offset_target;  // pc part added in branch_unit
    } dec_ctrl_t;

    typedef struct packed {
        logic              flag;
        logic [DATA_W-1:0] target;
        logic              next_in_delayslot;
    } branch_res_t;

    typedef struct packed {
        alu_op_e               alu_op;
        alu_sel_e              alu_sel;
        logic [DATA_W-1:0]     operand1;
        logic [DATA_W-1:0]     operand2;
        logic                  wr_en;
        logic [REG_ADDR_W-1:0] wr_addr;
        logic [DATA_W-1:0]     link_addr;
        logic                  in_delayslot;
    } id_ex_t;

endpackage

// ==== design/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder import id_pkg::*; (
    input  logic [DATA_W-1:0] inst_i,
    output dec_ctrl_t         ctrl_o
);

    opcode_e               opcode;
    funct_e                funct;
    regimm_e               regimm;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [4:0]            shamt;
    logic [15:0]           imm16;
    logic [DATA_W-1:0]     imm_zext;
    logic [DATA_W-1:0]     imm_sext;
    logic [DATA_W-1:0]     br_offset;
    logic [DATA_W-1:0]     jmp_index;

    assign opcode = opcode_e'(inst_i[31:26]);
    assign funct  = funct_e'(inst_i[5:0]);
    assign regimm = regimm_e'(inst_i[20:16]);
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign imm16  = inst_i[15:0];

    assign imm_zext  = {16'h0000, imm16};
    assign imm_sext  = {{16{imm16[15]}}, imm16};
    assign br_offset = {{14{imm16[15]}}, imm16, 2'b00};
    assign jmp_index = {4'h0, inst_i[25:0], 2'b00};

    always_comb begin
        ctrl_o               = '0;
        ctrl_o.alu_op        = ALU_NOP;
        ctrl_o.alu_sel       = SEL_NOP;
        ctrl_o.branch_kind   = BR_NONE;
        ctrl_o.rd_addr1      = rs;
        ctrl_o.rd_addr2      = rt;
        ctrl_o.wr_addr       = rd;
        ctrl_o.offset_target = br_offset;

        case (opcode)
            OP_SPECIAL: begin
                ctrl_o.rd_en1 = 1'b1;
                ctrl_o.rd_en2 = 1'b1;
                ctrl_o.wr_en  = 1'b1;
                case (funct)
                    FN_AND:  {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_AND, SEL_LOGIC};
                    FN_OR:   {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_OR, SEL_LOGIC};
                    FN_XOR:  {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_XOR, SEL_LOGIC};
                    FN_NOR:  {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_NOR, SEL_LOGIC};
                    FN_SLLV: {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_SLL, SEL_SHIFT};
                    FN_SRLV: {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_SRL, SEL_SHIFT};
                    FN_SRAV: {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_SRA, SEL_SHIFT};
                    FN_ADD:  {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_ADD, SEL_ARITH};
                    FN_ADDU: {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_ADDU, SEL_ARITH};
                    FN_SUB:  {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_SUB, SEL_ARITH};
                    FN_SUBU: {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_SUBU, SEL_ARITH};
                    FN_SLT:  {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_SLT, SEL_ARITH};
                    FN_SLTU: {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_SLTU, SEL_ARITH};
                    FN_SLL, FN_SRL, FN_SRA: begin
                        // shamt forms need rs == 0
                        if (rs == '0) begin
                            ctrl_o.alu_sel = SEL_SHIFT;
                            ctrl_o.rd_en1  = 1'b0;  // operand1 takes shamt
                            ctrl_o.imm     = {27'h0, shamt};
                            case (funct)
                                FN_SLL:  ctrl_o.alu_op = ALU_SLL;
                                FN_SRL:  ctrl_o.alu_op = ALU_SRL;
                                default: ctrl_o.alu_op = ALU_SRA;
                            endcase
                        end else begin
                            {ctrl_o.rd_en1, ctrl_o.rd_en2, ctrl_o.wr_en} = 3'b000;
                        end
                    end
                    FN_JR: begin
                        ctrl_o.alu_sel     = SEL_JUMP;
                        ctrl_o.rd_en2      = 1'b0;
                        ctrl_o.wr_en       = 1'b0;
                        ctrl_o.branch_kind = BR_JR;
                    end
                    FN_JALR: begin
                        {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_LINK, SEL_JUMP};
                        ctrl_o.rd_en2      = 1'b0;
                        ctrl_o.branch_kind = BR_JR;
                        ctrl_o.link        = 1'b1;
                    end
                    default: {ctrl_o.rd_en1, ctrl_o.rd_en2, ctrl_o.wr_en} = 3'b000;
                endcase
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                ctrl_o.rd_en1  = 1'b1;
                ctrl_o.wr_en   = 1'b1;
                ctrl_o.wr_addr = rt;
                ctrl_o.imm     = imm_sext;
                case (opcode)
                    OP_ANDI: {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_AND, SEL_LOGIC};
                    OP_ORI:  {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_OR, SEL_LOGIC};
                    OP_XORI: {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_XOR, SEL_LOGIC};
                    OP_LUI:  {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_OR, SEL_LOGIC};
                    OP_ADDI: {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_ADD, SEL_ARITH};
                    OP_ADDIU: {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_ADDU, SEL_ARITH};
                    OP_SLTI: {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_SLT, SEL_ARITH};
                    default: {ctrl_o.alu_op, ctrl_o.alu_sel} = {ALU_SLTU, SEL_ARITH};
                endcase
                if (opcode == OP_LUI)
                    ctrl_o.imm = {imm16, 16'h0000};  // or with $zero gives the upper half
                else if (ctrl_o.alu_sel == SEL_LOGIC)
                    ctrl_o.imm = imm_zext;
            end
            OP_J, OP_JAL: begin
                ctrl_o.alu_sel       = SEL_JUMP;
                ctrl_o.branch_kind   = BR_J;
                ctrl_o.offset_target = jmp_index;
                if (opcode == OP_JAL) begin
                    ctrl_o.alu_op  = ALU_LINK;
                    ctrl_o.wr_en   = 1'b1;
                    ctrl_o.wr_addr = REG_ADDR_W'(LINK_REG);
                    ctrl_o.link    = 1'b1;
                end
            end
            OP_BEQ, OP_BNE: begin
                ctrl_o.alu_sel     = SEL_JUMP;
                ctrl_o.rd_en1      = 1'b1;
                ctrl_o.rd_en2      = 1'b1;
                ctrl_o.branch_kind = (opcode == OP_BEQ) ? BR_EQ : BR_NE;
            end
            OP_BGTZ, OP_BLEZ: begin
                ctrl_o.alu_sel     = SEL_JUMP;
                ctrl_o.rd_en1      = 1'b1;
                ctrl_o.branch_kind = (opcode == OP_BGTZ) ? BR_GTZ : BR_LEZ;
            end
            OP_REGIMM: begin
                ctrl_o.alu_sel = SEL_JUMP;
                ctrl_o.rd_en1  = 1'b1;
                case (regimm)
                    RI_BGEZ, RI_BGEZAL: ctrl_o.branch_kind = BR_GEZ;
                    RI_BLTZ, RI_BLTZAL: ctrl_o.branch_kind = BR_LTZ;
                    default: {ctrl_o.alu_sel, ctrl_o.rd_en1} = {SEL_NOP, 1'b0};
                endcase
                if (regimm == RI_BGEZAL || regimm == RI_BLTZAL) begin
                    ctrl_o.alu_op  = ALU_LINK;
                    ctrl_o.wr_en   = 1'b1;
                    ctrl_o.wr_addr = REG_ADDR_W'(LINK_REG);
                    ctrl_o.link    = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== design/operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward import id_pkg::*; (
    input  logic                  rd_en_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  logic [DATA_W-1:0]     imm_i,
    input  logic [DATA_W-1:0]     reg_data_i,
    input  fwd_t                  ex_fwd_i,
    input  fwd_t                  mem_fwd_i,
    output logic [DATA_W-1:0]     operand_o
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_fwd_i.en && (ex_fwd_i.addr == rd_addr_i);
    assign mem_hit = mem_fwd_i.en && (mem_fwd_i.addr == rd_addr_i);

    always_comb begin
        if (!rd_en_i)
            operand_o = imm_i;
        else if (ex_hit)
            operand_o = ex_fwd_i.data;  // youngest result wins
        else if (mem_hit)
            operand_o = mem_fwd_i.data;
        else
            operand_o = reg_data_i;
    end

endmodule

// ==== design/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit import id_pkg::*; (
    input  logic              valid_i,
    input  logic [DATA_W-1:0] pc_i,
    input  branch_kind_e      kind_i,
    input  logic              link_i,
    input  logic [DATA_W-1:0] offset_target_i,
    input  logic [DATA_W-1:0] op1_i,
    input  logic [DATA_W-1:0] op2_i,
    output branch_res_t       branch_o,
    output logic [DATA_W-1:0] link_addr_o
);

    logic [DATA_W-1:0] pc_plus4;
    logic [DATA_W-1:0] pc_plus8;
    logic [DATA_W-1:0] target;
    logic              taken;

    assign pc_plus4 = pc_i + DATA_W'(4);
    assign pc_plus8 = pc_i + DATA_W'(8);

    always_comb begin
        target = pc_plus4 + offset_target_i;
        case (kind_i)
            BR_J: begin
                taken  = 1'b1;
                target = {pc_plus4[31:28], offset_target_i[27:0]};  // same 256MB region
            end
            BR_JR: begin
                taken  = 1'b1;
                target = op1_i;
            end
            BR_EQ:   taken = (op1_i == op2_i);
            BR_NE:   taken = (op1_i != op2_i);
            BR_GTZ:  taken = ($signed(op1_i) > 0);
            BR_LEZ:  taken = ($signed(op1_i) <= 0);
            BR_GEZ:  taken = ~op1_i[DATA_W-1];
            BR_LTZ:  taken = op1_i[DATA_W-1];
            default: taken = 1'b0;
        endcase
    end

    // redirect only for a valid, taken branch
    always_comb begin
        branch_o = '0;
        if (valid_i && taken) begin
            branch_o.flag              = 1'b1;
            branch_o.target            = target;
            branch_o.next_in_delayslot = 1'b1;
        end
    end

    assign link_addr_o = link_i ? pc_plus8 : ZERO_WORD;  // return past the delay slot

endmodule

// ==== design/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg import id_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   valid_i,
    input  id_ex_t ex_i,
    output id_ex_t ex_o,
    output logic   ex_valid_o
);

    always_ff @(posedge clk) begin
        ex_o <= ex_i;
        if (rst) begin
            ex_valid_o <= 1'b0;
            ex_o.wr_en <= 1'b0;
        end else begin
            ex_valid_o <= valid_i;
            ex_o.wr_en <= ex_i.wr_en & valid_i;  // bubbles never write back
        end
    end

endmodule

// ==== design/id_stage_top.sv ====
`timescale 1ns/1ps

module id_stage_top import id_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  valid_i,
    input  logic [DATA_W-1:0]     inst_addr_i,
    input  logic [DATA_W-1:0]     inst_data_i,
    input  logic [DATA_W-1:0]     reg_data1_i,
    input  logic [DATA_W-1:0]     reg_data2_i,
    input  fwd_t                  ex_fwd_i,
    input  fwd_t                  mem_fwd_i,
    input  logic                  in_delayslot_i,
    output logic                  rd_en1_o,
    output logic                  rd_en2_o,
    output logic [REG_ADDR_W-1:0] rd_addr1_o,
    output logic [REG_ADDR_W-1:0] rd_addr2_o,
    output branch_res_t           branch_o,
    output id_ex_t                ex_o,
    output logic                  ex_valid_o
);

    dec_ctrl_t         dec_ctrl;
    logic [DATA_W-1:0] operand1;
    logic [DATA_W-1:0] operand2;
    logic [DATA_W-1:0] link_addr;
    id_ex_t            id_ex;

    inst_decoder u_dec (
        .inst_i (inst_data_i),
        .ctrl_o (dec_ctrl)
    );

    // regfile read port controls
    assign rd_en1_o   = dec_ctrl.rd_en1;
    assign rd_en2_o   = dec_ctrl.rd_en2;
    assign rd_addr1_o = dec_ctrl.rd_addr1;
    assign rd_addr2_o = dec_ctrl.rd_addr2;

    operand_forward u_fwd1 (
        .rd_en_i    (dec_ctrl.rd_en1),
        .rd_addr_i  (dec_ctrl.rd_addr1),
        .imm_i      (dec_ctrl.imm),
        .reg_data_i (reg_data1_i),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .operand_o  (operand1)
    );

    operand_forward u_fwd2 (
        .rd_en_i    (dec_ctrl.rd_en2),
        .rd_addr_i  (dec_ctrl.rd_addr2),
        .imm_i      (dec_ctrl.imm),
        .reg_data_i (reg_data2_i),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .operand_o  (operand2)
    );

    branch_unit u_branch (
        .valid_i         (valid_i),
        .pc_i            (inst_addr_i),
        .kind_i          (dec_ctrl.branch_kind),
        .link_i          (dec_ctrl.link),
        .offset_target_i (dec_ctrl.offset_target),
        .op1_i           (operand1),
        .op2_i           (operand2),
        .branch_o        (branch_o),
        .link_addr_o     (link_addr)
    );

    assign id_ex.alu_op       = dec_ctrl.alu_op;
    assign id_ex.alu_sel      = dec_ctrl.alu_sel;
    assign id_ex.operand1     = operand1;
    assign id_ex.operand2     = operand2;
    assign id_ex.wr_en        = dec_ctrl.wr_en;
    assign id_ex.wr_addr      = dec_ctrl.wr_addr;
    assign id_ex.link_addr    = link_addr;
    assign id_ex.in_delayslot = in_delayslot_i;

    id_ex_reg u_id_ex (
        .clk        (clk),
        .rst        (rst),
        .valid_i    (valid_i),
        .ex_i       (id_ex),
        .ex_o       (ex_o),
        .ex_valid_o (ex_valid_o)
    );

endmodule

// ==== verif/id_stage_checker.sv ====
`timescale 1ns/1ps

module id_stage_checker import id_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        valid_i,
    input branch_res_t branch_o,
    input logic        ex_valid_o
);

    // register cleared by reset
    assert property (@(posedge clk) rst |=> !ex_valid_o)
        else $error("ex_valid_o high after reset");

    assert property (@(posedge clk) disable iff (rst)
                     branch_o.flag |-> branch_o.next_in_delayslot)
        else $error("taken branch without delay-slot mark");

    // bubbles stay bubbles
    assert property (@(posedge clk) disable iff (rst) !valid_i |=> !ex_valid_o)
        else $error("ex_valid_o high after an invalid input");

endmodule

bind id_stage_top id_stage_checker u_chk (
    .clk        (clk),
    .rst        (rst),
    .valid_i    (valid_i),
    .branch_o   (branch_o),
    .ex_valid_o (ex_valid_o)
);

// ==== verif/id_stage_tb.sv ====
`timescale 1ns/1ps

module id_stage_tb import id_pkg::*; ();

    localparam int MAX_VEC = 64;

    logic                  clk;
    logic                  rst;
    logic                  valid_i;
    logic [DATA_W-1:0]     inst_addr_i;
    logic [DATA_W-1:0]     inst_data_i;
    logic [DATA_W-1:0]     reg_data1_i;
    logic [DATA_W-1:0]     reg_data2_i;
    fwd_t                  ex_fwd_i;
    fwd_t                  mem_fwd_i;
    logic                  in_delayslot_i;
    logic                  rd_en1_o;
    logic                  rd_en2_o;
    logic [REG_ADDR_W-1:0] rd_addr1_o;
    logic [REG_ADDR_W-1:0] rd_addr2_o;
    branch_res_t           branch_o;
    id_ex_t                ex_o;
    logic                  ex_valid_o;

    // stimulus and expected values per vector
    logic              vec_valid [MAX_VEC];
    logic [DATA_W-1:0] vec_pc [MAX_VEC];
    logic [DATA_W-1:0] vec_inst [MAX_VEC];
    logic [DATA_W-1:0] vec_r1 [MAX_VEC];
    logic [DATA_W-1:0] vec_r2 [MAX_VEC];
    fwd_t              vec_ex_fwd [MAX_VEC];
    fwd_t              vec_mem_fwd [MAX_VEC];
    logic              vec_ds [MAX_VEC];
    logic              exp_en1 [MAX_VEC];
    logic              exp_en2 [MAX_VEC];
    branch_res_t       exp_br [MAX_VEC];
    id_ex_t            exp_ex [MAX_VEC];
    int                num_vec;
    int                errors;

    id_stage_top dut0 (
        .clk            (clk),
        .rst            (rst),
        .valid_i        (valid_i),
        .inst_addr_i    (inst_addr_i),
        .inst_data_i    (inst_data_i),
        .reg_data1_i    (reg_data1_i),
        .reg_data2_i    (reg_data2_i),
        .ex_fwd_i       (ex_fwd_i),
        .mem_fwd_i      (mem_fwd_i),
        .in_delayslot_i (in_delayslot_i),
        .rd_en1_o       (rd_en1_o),
        .rd_en2_o       (rd_en2_o),
        .rd_addr1_o     (rd_addr1_o),
        .rd_addr2_o     (rd_addr2_o),
        .branch_o       (branch_o),
        .ex_o           (ex_o),
        .ex_valid_o     (ex_valid_o)
    );

    always #10 clk = ~clk;

    task automatic report_failure();
        errors++;
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_addr(input string name, input logic [REG_ADDR_W-1:0] exp,
                              input logic [REG_ADDR_W-1:0] act);
        if (act !== exp) begin
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_branch(input branch_res_t exp);
        if (branch_o !== exp) begin
            $display("error at %0t ns: branch_o expected flag %b target %h nds %b, got %b %h %b",
                     $time, exp.flag, exp.target, exp.next_in_delayslot,
                     branch_o.flag, branch_o.target, branch_o.next_in_delayslot);
            report_failure();
        end
    endtask

    task automatic check_ex(input id_ex_t exp);
        id_ex_t act;
        act = ex_o;
        if (!exp.wr_en)
            act.wr_addr = exp.wr_addr;  // no destination without a write
        if (act !== exp) begin
            $display("error at %0t ns: ex_o expected %h, got %h", $time, exp, ex_o);
            report_failure();
        end
    endtask

    task automatic check_stage_out(input int j);
        check_bit("ex_valid_o", vec_valid[j], ex_valid_o);
        if (vec_valid[j])
            check_ex(exp_ex[j]);
        else
            check_bit("ex_o.wr_en", 1'b0, ex_o.wr_en);
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        logic [31:0] v, pc, ins, r1, r2, xe, xa, xd, me, ma, md, ds;
        logic [31:0] e1, e2, bf, bt, bn, op1, op2, aop, asel, we, wa, lnk;
        fd = $fopen("verif/id_stage_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file verif/id_stage_input.txt");
            report_failure();
        end
        num_vec = 0;
        while (!$feof(fd) && num_vec < MAX_VEC) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 8 || line[0] == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v, pc, ins, r1, r2, xe, xa, xd, me, ma, md, ds,
                        e1, e2, bf, bt, bn, op1, op2, aop, asel, we, wa, lnk);
            if (n != 24) begin
                $display("malformed vector line: %s", line);
                report_failure();
            end
            vec_valid[num_vec]   = v[0];
            vec_pc[num_vec]      = pc;
            vec_inst[num_vec]    = ins;
            vec_r1[num_vec]      = r1;
            vec_r2[num_vec]      = r2;
            vec_ex_fwd[num_vec]  = '{en: xe[0], addr: xa[4:0], data: xd};
            vec_mem_fwd[num_vec] = '{en: me[0], addr: ma[4:0], data: md};
            vec_ds[num_vec]      = ds[0];
            exp_en1[num_vec]     = e1[0];
            exp_en2[num_vec]     = e2[0];
            exp_br[num_vec]      = '{flag: bf[0], target: bt, next_in_delayslot: bn[0]};
            exp_ex[num_vec] = '{alu_op: alu_op_e'(aop[3:0]), alu_sel: alu_sel_e'(asel[2:0]),
                                operand1: op1, operand2: op2, wr_en: we[0],
                                wr_addr: wa[4:0], link_addr: lnk, in_delayslot: ds[0]};
            num_vec++;
        end
        $fclose(fd);
        if (num_vec == 0) begin
            $display("the vector file holds no vectors");
            report_failure();
        end
    endtask

    initial begin
        int cnt;
        void'($urandom(45));
        errors = 0;
        clk = 1'b0;
        rst = 1'b1;
        valid_i = 1'b0;
        inst_addr_i = '0;
        inst_data_i = '0;
        reg_data1_i = '0;
        reg_data2_i = '0;
        ex_fwd_i = '0;
        mem_fwd_i = '0;
        in_delayslot_i = 1'b0;
        load_vectors();

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        cnt = 0;
        do begin  // wait for reset release
            @(negedge clk);
            cnt++;
            if (cnt > 10) begin
                $display("reset did not end within 10 cycles");
                report_failure();
            end
        end while (rst || ex_valid_o);
        // all-zero word decodes as a writing sll
        check_bit("ex_o.wr_en", 1'b0, ex_o.wr_en);

        for (int i = 0; i < num_vec; i++) begin
            @(posedge clk);
            valid_i        <= vec_valid[i];
            inst_addr_i    <= vec_pc[i];
            inst_data_i    <= vec_inst[i];
            reg_data1_i    <= exp_en1[i] ? vec_r1[i] : $urandom();  // unread port
            reg_data2_i    <= exp_en2[i] ? vec_r2[i] : $urandom();
            ex_fwd_i       <= vec_ex_fwd[i];
            mem_fwd_i      <= vec_mem_fwd[i];
            in_delayslot_i <= vec_ds[i];
            @(negedge clk);
            check_bit("rd_en1_o", exp_en1[i], rd_en1_o);
            check_bit("rd_en2_o", exp_en2[i], rd_en2_o);
            if (exp_en1[i])
                check_addr("rd_addr1_o", vec_inst[i][25:21], rd_addr1_o);  // rs field
            if (exp_en2[i])
                check_addr("rd_addr2_o", vec_inst[i][20:16], rd_addr2_o);  // rt field
            check_branch(exp_br[i]);
            if (i > 0)
                check_stage_out(i - 1);  // previous vector leaves the register
        end

        @(posedge clk);
        valid_i <= 1'b0;
        @(negedge clk);
        cnt = 0;
        while (vec_valid[num_vec-1] && !ex_valid_o) begin
            if (cnt == 2) begin
                $display("ex_valid_o never rose for the last vector");
                report_failure();
            end
            @(negedge clk);
            cnt++;
        end
        check_stage_out(num_vec - 1);

        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/id_stage_input.txt ====
# valid pc inst reg1 reg2 exen exaddr exdata memen memaddr memdata delayslot
# exp: rden1 rden2 brflag brtarget brnds op1 op2 aluop alusel wren wraddr linkaddr
1 00001000 00221821 00000005 00000007 0 00 00000000 0 00 00000000 0 1 1 0 00000000 0 00000005 00000007 9 3 1 03 00000000
1 00001004 00221824 f0f0f0f0 0ff00ff0 0 00 00000000 0 00 00000000 0 1 1 0 00000000 0 f0f0f0f0 0ff00ff0 1 1 1 03 00000000
1 00001008 00221827 12345678 00000000 0 00 00000000 0 00 00000000 0 1 1 0 00000000 0 12345678 00000000 4 1 1 03 00000000
1 0000100c 0022182a ffffffff 00000001 0 00 00000000 0 00 00000000 0 1 1 0 00000000 0 ffffffff 00000001 c 3 1 03 00000000
1 00001010 00021900 00000000 0000abcd 0 00 00000000 0 00 00000000 0 0 1 0 00000000 0 00000004 0000abcd 5 2 1 03 00000000
1 00001014 00221807 00000003 80000000 0 00 00000000 0 00 00000000 0 1 1 0 00000000 0 00000003 80000000 7 2 1 03 00000000
1 00001018 30228001 ffffffff 00000000 0 00 00000000 0 00 00000000 0 1 0 0 00000000 0 ffffffff 00008001 1 1 1 02 00000000
1 0000101c 20228001 00000010 00000000 0 00 00000000 0 00 00000000 0 1 0 0 00000000 0 00000010 ffff8001 8 3 1 02 00000000
1 00001020 2c22ffff 00000001 00000000 0 00 00000000 0 00 00000000 0 1 0 0 00000000 0 00000001 ffffffff d 3 1 02 00000000
1 00001024 3c021234 00000000 00000000 0 00 00000000 0 00 00000000 0 1 0 0 00000000 0 00000000 12340000 2 1 1 02 00000000
1 00001028 00221821 aaaaaaaa bbbbbbbb 1 01 11111111 1 01 22222222 0 1 1 0 00000000 0 11111111 bbbbbbbb 9 3 1 03 00000000
1 0000102c 00221821 aaaaaaaa bbbbbbbb 1 05 33333333 1 02 44444444 0 1 1 0 00000000 0 aaaaaaaa 44444444 9 3 1 03 00000000
1 00001030 00221821 aaaaaaaa bbbbbbbb 0 01 55555555 0 02 66666666 0 1 1 0 00000000 0 aaaaaaaa bbbbbbbb 9 3 1 03 00000000
1 00002000 10220004 00000009 00000009 0 00 00000000 0 00 00000000 0 1 1 1 00002014 1 00000009 00000009 0 4 0 00 00000000
1 00002004 10220004 00000009 00000008 0 00 00000000 0 00 00000000 0 1 1 0 00000000 0 00000009 00000008 0 4 0 00 00000000
1 00002008 1422fffe 00000001 00000002 0 00 00000000 0 00 00000000 0 1 1 1 00002004 1 00000001 00000002 0 4 0 00 00000000
1 00002010 1c200010 00000001 00000000 0 00 00000000 0 00 00000000 0 1 0 1 00002054 1 00000001 00000000 0 4 0 00 00000000
1 00002014 1c200010 80000000 00000000 0 00 00000000 0 00 00000000 0 1 0 0 00000000 0 80000000 00000000 0 4 0 00 00000000
1 00002018 18200010 00000000 00000000 0 00 00000000 0 00 00000000 0 1 0 1 0000205c 1 00000000 00000000 0 4 0 00 00000000
1 0000201c 04210010 80000000 00000000 0 00 00000000 0 00 00000000 0 1 0 0 00000000 0 80000000 00000000 0 4 0 00 00000000
1 00003000 04300010 ffffffff 00000000 0 00 00000000 0 00 00000000 0 1 0 1 00003044 1 ffffffff 00000000 e 4 1 1f 00003008
1 00003004 00221821 00000001 00000002 0 00 00000000 0 00 00000000 1 1 1 0 00000000 0 00000001 00000002 9 3 1 03 00000000
1 40000000 08000100 00000000 00000000 0 00 00000000 0 00 00000000 0 0 0 1 40000400 1 00000000 00000000 0 4 0 00 00000000
1 50000010 0c000040 00000000 00000000 0 00 00000000 0 00 00000000 0 0 0 1 50000100 1 00000000 00000000 e 4 1 1f 50000018
1 00006000 00200008 00000100 00000000 1 01 00008000 0 00 00000000 0 1 0 1 00008000 1 00008000 00000000 0 4 0 00 00000000
1 00006010 00201809 00004000 00000000 0 00 00000000 0 00 00000000 0 1 0 1 00004000 1 00004000 00000000 e 4 1 03 00006018
0 00002000 10220004 00000009 00000009 0 00 00000000 0 00 00000000 0 1 1 0 00000000 0 00000009 00000009 0 4 0 00 00000000
1 00006014 00221821 00000005 00000007 0 00 00000000 0 00 00000000 1 1 1 0 00000000 0 00000005 00000007 9 3 1 03 00000000

// ==== vlog.f ====
design/id_pkg.sv
design/inst_decoder.sv
design/operand_forward.sv
design/branch_unit.sv
design/id_ex_reg.sv
design/id_stage_top.sv
verif/id_stage_checker.sv
verif/id_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decode stage testbench, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module id_stage_tb -f vlog.f -o id_stage_sim &&
./obj_dir/id_stage_sim | grep -q "ALL TESTS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
